// File: rtl/shell_cfg_pkg.sv
// Hold lengths are sized for simulation; SYS_DIV must be even and LDR_CREDITS a power of two
package shell_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Clock-enable periods, in clk_sys cycles
	////////////////////////////////////////////////////////////////////////////

	// System enable, CPU phases derive from it
	localparam int SYS_DIV      = 4;
	// Sound enable, mode 0
	localparam int SND_DIV_FAST = 5;
	// Sound enable in mode 1, also FM timer 0
	localparam int SND_DIV_SLOW = 10;
	// FM timer 1
	localparam int OPM_DIV      = 20;

	////////////////////////////////////////////////////////////////////////////
	// Media and reset hold lengths
	////////////////////////////////////////////////////////////////////////////

	localparam int MOUNT_HOLD     = 1024;
	// Eject window at mount start or after an eject request
	localparam int EJECT_HOLD     = 256;
	localparam int HDD_RESET_HOLD = 512;
	// Disk LED afterglow
	localparam int LED_HOLD       = 64;

	////////////////////////////////////////////////////////////////////////////
	// Loader and drive counts
	////////////////////////////////////////////////////////////////////////////

	// Credits granted by the core, equal to the FIFO depth
	localparam int LDR_CREDITS = 4;
	// Floppy 0, floppy 1, hard disk, SRAM image
	localparam int NUM_DRIVES  = 4;
	localparam int NUM_FDD     = 2;

endpackage

// File: rtl/shell_types_pkg.sv
// Drive masks take their widths from shell_cfg_pkg, so that package must be compiled first
package shell_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////////////////////

	// Byte address into the core memory map
	typedef logic [19:0] ldr_addr_t;
	typedef logic [7:0]  ldr_data_t;

	// Wide enough for MOUNT_HOLD, the longest hold
	typedef logic [10:0] hold_cnt_t;

	// One bit per drive, floppies in the low bits
	typedef logic [shell_cfg_pkg::NUM_DRIVES-1:0] drive_mask_t;
	typedef logic [shell_cfg_pkg::NUM_FDD-1:0]    fdd_mask_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// One loader write toward the core
	typedef struct packed {
		logic      valid;
		ldr_addr_t addr;
		ldr_data_t data;
	} ldr_word_t;

	// Menu and button requests from the host
	typedef struct packed {
		logic      user_reset;
		logic      turbo;
		logic      snd_mode;
		fdd_mask_t fdd_eject;
	} ctrl_req_t;

	// Disk LED state machine
	typedef enum logic {
		LED_OFF,
		LED_ON
	} led_state_t;

endpackage

// File: rtl/ce_generator.sv
// All enables are registered one-cycle pulses; turbo takes effect only at a system-enable boundary
`timescale 1ns/1ps

module ce_generator (
	input  logic       clk_sys,
	input  logic       reset_delayed,
	input  logic       turbo_i,
	input  logic       snd_mode_i,
	output logic       sys_ce_o,
	output logic       mpu_cep_o,
	output logic       mpu_cen_o,
	output logic       snd_ce_o,
	output logic [1:0] opm_ce_o
);

	logic [$clog2(shell_cfg_pkg::SYS_DIV)-1:0]      div_sys;
	logic [$clog2(shell_cfg_pkg::SND_DIV_FAST)-1:0] div_snd;
	logic [$clog2(shell_cfg_pkg::SND_DIV_SLOW)-1:0] div_snd2;
	logic [$clog2(shell_cfg_pkg::OPM_DIV)-1:0]      div_opm;
	logic turbo_q;

	// Last count of each divider
	logic sys_wrap, fast_wrap, slow_wrap, opm_wrap;
	// Normal-mode falling phase, half a system period before cep
	logic cen_slot;

	assign sys_wrap  = int'(div_sys) == shell_cfg_pkg::SYS_DIV - 1;
	assign cen_slot  = int'(div_sys) == shell_cfg_pkg::SYS_DIV / 2 - 1;
	assign fast_wrap = int'(div_snd) == shell_cfg_pkg::SND_DIV_FAST - 1;
	assign slow_wrap = int'(div_snd2) == shell_cfg_pkg::SND_DIV_SLOW - 1;
	assign opm_wrap  = int'(div_opm) == shell_cfg_pkg::OPM_DIV - 1;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys   <= '0;
			div_snd   <= '0;
			div_snd2  <= '0;
			div_opm   <= '0;
			turbo_q   <= 1'b0;
			sys_ce_o  <= 1'b0;
			mpu_cep_o <= 1'b0;
			mpu_cen_o <= 1'b0;
			snd_ce_o  <= 1'b0;
			opm_ce_o  <= '0;
		end else begin
			div_sys  <= sys_wrap  ? '0 : div_sys + 1'b1;
			div_snd  <= fast_wrap ? '0 : div_snd + 1'b1;
			div_snd2 <= slow_wrap ? '0 : div_snd2 + 1'b1;
			div_opm  <= opm_wrap  ? '0 : div_opm + 1'b1;

			sys_ce_o <= sys_wrap;
			// Change speed only between CPU cycles
			if (sys_wrap)
				turbo_q <= turbo_i;

			// Turbo runs one phase per clock
			mpu_cep_o <= turbo_q ?  div_sys[0] : sys_wrap;
			mpu_cen_o <= turbo_q ? ~div_sys[0] : cen_slot;

			snd_ce_o <= snd_mode_i ? slow_wrap : fast_wrap;
			opm_ce_o <= {opm_wrap, slow_wrap};
		end
	end

endmodule

// File: rtl/media_reset_seq.sv
// Drive 2 is the hard disk; mount pulses are one cycle, eject requests reload while held high
`timescale 1ns/1ps

module media_reset_seq (
	input  logic                         clk_sys,
	input  logic                         reset_delayed,
	input  shell_types_pkg::drive_mask_t img_mounted_i,
	input  logic                         user_reset_i,
	input  shell_types_pkg::fdd_mask_t   fdd_eject_req_i,
	input  logic                         dl_active_i,
	output shell_types_pkg::drive_mask_t mounted_o,
	output shell_types_pkg::fdd_mask_t   fdd_eject_o,
	output logic                         core_reset_o
);

	shell_types_pkg::hold_cnt_t mount_cnt [shell_cfg_pkg::NUM_DRIVES];
	shell_types_pkg::hold_cnt_t eject_cnt [shell_cfg_pkg::NUM_FDD];
	shell_types_pkg::hold_cnt_t hdd_cnt;

	logic hdd_mnt_q;
	logic dl_active_q;
	logic dl_seen_q;
	logic hdd_rise;
	logic dl_rise;
	shell_types_pkg::fdd_mask_t fdd_mounted;

	assign hdd_rise = img_mounted_i[2] & ~hdd_mnt_q;
	assign dl_rise  = dl_active_i & ~dl_active_q;

	////////////////////////////////////////////////////////////////////////////
	// Hold counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int n = 0; n < shell_cfg_pkg::NUM_DRIVES; n++)
				mount_cnt[n] <= '0;
			for (int n = 0; n < shell_cfg_pkg::NUM_FDD; n++)
				eject_cnt[n] <= '0;
			hdd_cnt      <= '0;
			hdd_mnt_q    <= 1'b0;
			dl_active_q  <= 1'b0;
			dl_seen_q    <= 1'b0;
			core_reset_o <= 1'b1;
		end else begin
			for (int n = 0; n < shell_cfg_pkg::NUM_DRIVES; n++) begin
				if (img_mounted_i[n])
					mount_cnt[n] <= shell_types_pkg::hold_cnt_t'(shell_cfg_pkg::MOUNT_HOLD);
				else if (mount_cnt[n] != '0)
					mount_cnt[n] <= mount_cnt[n] - 1'b1;
			end
			for (int n = 0; n < shell_cfg_pkg::NUM_FDD; n++) begin
				if (fdd_eject_req_i[n])
					eject_cnt[n] <= shell_types_pkg::hold_cnt_t'(shell_cfg_pkg::EJECT_HOLD);
				else if (eject_cnt[n] != '0)
					eject_cnt[n] <= eject_cnt[n] - 1'b1;
			end

			// New hard disk image needs a fresh boot
			if (hdd_rise)
				hdd_cnt <= shell_types_pkg::hold_cnt_t'(shell_cfg_pkg::HDD_RESET_HOLD);
			else if (hdd_cnt != '0)
				hdd_cnt <= hdd_cnt - 1'b1;

			hdd_mnt_q   <= img_mounted_i[2];
			dl_active_q <= dl_active_i;
			// Core stays in reset until the first ROM download starts
			if (dl_rise)
				dl_seen_q <= 1'b1;

			core_reset_o <= ~dl_seen_q | user_reset_i | (hdd_cnt != '0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Drive status toward the core
	////////////////////////////////////////////////////////////////////////////

	// Floppies see an eject first, then the inserted disk
	always_comb begin
		for (int n = 0; n < shell_cfg_pkg::NUM_DRIVES; n++)
			mounted_o[n] = mount_cnt[n] != '0;
		for (int n = 0; n < shell_cfg_pkg::NUM_FDD; n++) begin
			fdd_eject_o[n] = (mount_cnt[n] > shell_types_pkg::hold_cnt_t'(
				shell_cfg_pkg::MOUNT_HOLD - shell_cfg_pkg::EJECT_HOLD)) || (eject_cnt[n] != '0);
			mounted_o[n] = (mount_cnt[n] != '0) && (eject_cnt[n] == '0) &&
				(mount_cnt[n] <= shell_types_pkg::hold_cnt_t'(
				shell_cfg_pkg::MOUNT_HOLD - shell_cfg_pkg::EJECT_HOLD));
		end
	end

	assign fdd_mounted = mounted_o[shell_cfg_pkg::NUM_FDD-1:0];

	// A floppy shows the inserted disk only after an eject window
	a_fdd_eject_before_mount: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		(fdd_mounted & ~$past(fdd_mounted) & ~$past(fdd_eject_o)) == '0);

endmodule

// File: rtl/loader_bridge.sv
// Host writes are never stalled; the host may not run more than LDR_CREDITS writes ahead of the core
`timescale 1ns/1ps

module loader_bridge (
	input  logic                       clk_sys,
	input  logic                       reset_delayed,
	input  logic                       dl_active_i,
	input  logic                       dl_wr_i,
	input  shell_types_pkg::ldr_addr_t dl_addr_i,
	input  shell_types_pkg::ldr_data_t dl_data_i,
	input  logic                       ldr_credit_i,
	output shell_types_pkg::ldr_word_t ldr_word_o,
	output logic                       ldr_enable_o
);

	typedef logic [$clog2(shell_cfg_pkg::LDR_CREDITS)-1:0] fifo_ptr_t;
	typedef logic [$clog2(shell_cfg_pkg::LDR_CREDITS):0]   fifo_cnt_t;

	shell_types_pkg::ldr_addr_t fifo_addr [shell_cfg_pkg::LDR_CREDITS];
	shell_types_pkg::ldr_data_t fifo_data [shell_cfg_pkg::LDR_CREDITS];
	fifo_ptr_t wr_ptr, rd_ptr;
	fifo_cnt_t fifo_count;
	fifo_cnt_t credit_cnt;

	shell_types_pkg::ldr_addr_t out_addr_q;
	shell_types_pkg::ldr_data_t out_data_q;
	logic out_valid_q;
	logic dl_active_q, end_seen_q, done_q;
	logic push, pop, fifo_full, dl_fall;

	assign push      = dl_wr_i & dl_active_i;
	// One word per credit held
	assign pop       = (credit_cnt != '0) && (fifo_count != '0);
	assign fifo_full = int'(fifo_count) == shell_cfg_pkg::LDR_CREDITS;
	assign dl_fall   = dl_active_q & ~dl_active_i;

	always_ff @(posedge clk_sys) begin
		if (push) begin
			fifo_addr[wr_ptr] <= dl_addr_i;
			fifo_data[wr_ptr] <= dl_data_i;
		end
		if (pop) begin
			out_addr_q <= fifo_addr[rd_ptr];
			out_data_q <= fifo_data[rd_ptr];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fifo_count  <= '0;
			credit_cnt  <= fifo_cnt_t'(shell_cfg_pkg::LDR_CREDITS);
			out_valid_q <= 1'b0;
			dl_active_q <= 1'b0;
			end_seen_q  <= 1'b0;
			done_q      <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fifo_count <= fifo_count + 1'b1;
				2'b01:   fifo_count <= fifo_count - 1'b1;
				default: ;
			endcase
			case ({pop, ldr_credit_i})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: ;
			endcase
			out_valid_q <= pop;

			// Done once the download has ended and the FIFO has drained
			dl_active_q <= dl_active_i;
			if (dl_fall)
				end_seen_q <= 1'b1;
			if ((end_seen_q || dl_fall) && fifo_count == '0)
				done_q <= 1'b1;
		end
	end

	assign ldr_word_o   = '{valid: out_valid_q, addr: out_addr_q, data: out_data_q};
	assign ldr_enable_o = dl_active_i & ~done_q;

	// Host ran ahead of the credit window
	a_fifo_no_overflow: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		!(push && fifo_full && !pop));

	// Core returned more credits than it was given
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		int'(credit_cnt) <= shell_cfg_pkg::LDR_CREDITS);

endmodule

// File: rtl/activity_led.sv
// Each access restarts the LED_HOLD afterglow; the LED lights one cycle after the access
`timescale 1ns/1ps

module activity_led (
	input  logic clk_sys,
	input  logic reset_delayed,
	input  logic access_i,
	output logic led_o
);

	shell_types_pkg::led_state_t state_q;
	shell_types_pkg::hold_cnt_t  hold_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			state_q <= shell_types_pkg::LED_OFF;
			hold_q  <= '0;
		end else if (access_i) begin
			state_q <= shell_types_pkg::LED_ON;
			hold_q  <= shell_types_pkg::hold_cnt_t'(shell_cfg_pkg::LED_HOLD - 1);
		end else begin
			case (state_q)
				shell_types_pkg::LED_ON: begin
					if (hold_q == '0)
						state_q <= shell_types_pkg::LED_OFF;
					else
						hold_q <= hold_q - 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign led_o = state_q == shell_types_pkg::LED_ON;

endmodule

// File: rtl/guest_shell_top.sv
// Control shell only; the core, host SPI blocks, video and audio paths live outside this top
`timescale 1ns/1ps

module guest_shell_top (
	input  logic                         clk_sys,
	input  logic                         reset_delayed,
	input  shell_types_pkg::ctrl_req_t   ctrl_req_i,
	input  shell_types_pkg::drive_mask_t img_mounted_i,
	input  logic                         dl_active_i,
	input  logic                         dl_wr_i,
	input  shell_types_pkg::ldr_addr_t   dl_addr_i,
	input  shell_types_pkg::ldr_data_t   dl_data_i,
	input  shell_types_pkg::drive_mask_t sd_ack_i,
	input  logic                         ldr_credit_i,
	output logic                         sys_ce_o,
	output logic                         mpu_cep_o,
	output logic                         mpu_cen_o,
	output logic                         snd_ce_o,
	output logic [1:0]                   opm_ce_o,
	output shell_types_pkg::drive_mask_t mounted_o,
	output shell_types_pkg::fdd_mask_t   fdd_eject_o,
	output logic                         core_reset_o,
	output shell_types_pkg::ldr_word_t   ldr_word_o,
	output logic                         ldr_enable_o,
	output logic                         fdd_led_o,
	output logic                         hdd_led_o
);

	ce_generator i_ce_generator (
		.clk_sys, .reset_delayed,
		.turbo_i(ctrl_req_i.turbo), .snd_mode_i(ctrl_req_i.snd_mode),
		.sys_ce_o, .mpu_cep_o, .mpu_cen_o, .snd_ce_o, .opm_ce_o
	);

	media_reset_seq i_media_reset_seq (
		.clk_sys, .reset_delayed, .img_mounted_i,
		.user_reset_i(ctrl_req_i.user_reset), .fdd_eject_req_i(ctrl_req_i.fdd_eject),
		.dl_active_i, .mounted_o, .fdd_eject_o, .core_reset_o
	);

	loader_bridge i_loader_bridge (
		.clk_sys, .reset_delayed, .dl_active_i, .dl_wr_i, .dl_addr_i, .dl_data_i,
		.ldr_credit_i, .ldr_word_o, .ldr_enable_o
	);

	// Both floppies share one LED
	activity_led i_fdd_led (
		.clk_sys, .reset_delayed, .access_i(|sd_ack_i[1:0]), .led_o(fdd_led_o)
	);

	activity_led i_hdd_led (
		.clk_sys, .reset_delayed, .access_i(sd_ack_i[2]), .led_o(hdd_led_o)
	);

endmodule

// File: dv/tb_guest_shell.sv
// Fixed seed; inputs change 1 ns after the rising edge and outputs are sampled there too
`timescale 1ns/1ps

module tb_guest_shell;

	// Probe selectors with the drive index in the low bits
	localparam int SEL_EJECT    = 0;
	localparam int SEL_MOUNTED  = 4;
	localparam int SEL_CORE_RST = 8;
	localparam int WIN          = 200;
	localparam int NUM_WORDS    = 40;

	logic                         clk_sys;
	logic                         reset_delayed;
	shell_types_pkg::ctrl_req_t   ctrl_req_i;
	shell_types_pkg::drive_mask_t img_mounted_i;
	logic                         dl_active_i;
	logic                         dl_wr_i;
	shell_types_pkg::ldr_addr_t   dl_addr_i;
	shell_types_pkg::ldr_data_t   dl_data_i;
	shell_types_pkg::drive_mask_t sd_ack_i;
	logic                         ldr_credit_i;
	logic                         sys_ce_o, mpu_cep_o, mpu_cen_o, snd_ce_o;
	logic [1:0]                   opm_ce_o;
	shell_types_pkg::drive_mask_t mounted_o;
	shell_types_pkg::fdd_mask_t   fdd_eject_o;
	logic                         core_reset_o;
	shell_types_pkg::ldr_word_t   ldr_word_o;
	logic                         ldr_enable_o, fdd_led_o, hdd_led_o;

	guest_shell_top i_guest_shell_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
			input int tol = 0);
		int diff;
		diff = int'(got) - int'(exp);
		if ((tol == 0 && got !== exp) || diff > tol || diff < -tol) begin
			$display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("** FAIL **");
		$fatal(1, "wait timed out");
	endtask

	function automatic logic probe(input int sel);
		if (sel == SEL_CORE_RST)
			return core_reset_o;
		if (sel >= SEL_MOUNTED)
			return mounted_o[sel[1:0]];
		return fdd_eject_o[sel[0]];
	endfunction

	// Samples until the probe rises, then samples while it stays high
	task automatic measure_pulse(input int sel, input int limit, output int lead, output int width);
		lead = 0;
		width = 0;
		while (!probe(sel)) begin
			step();
			lead++;
			if (lead > limit)
				timeout_fail($sformatf("probe %0d never went high", sel));
		end
		while (probe(sel)) begin
			step();
			width++;
			if (width > limit)
				timeout_fail($sformatf("probe %0d never went low", sel));
		end
	endtask

	task automatic pulse_mount(input int d);
		img_mounted_i[d[1:0]] = 1'b1;
		step();
		img_mounted_i = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Behaviors
	////////////////////////////////////////////////////////////////////////////

	task automatic run_enable_windows();
		int n_sys, n_cep, n_cen, n_snd, n_opm0, n_opm1;
		int cpu_period, snd_period;
		for (int w = 0; w < 4; w++) begin
			ctrl_req_i.turbo    = 1'($urandom_range(1, 0));
			ctrl_req_i.snd_mode = 1'($urandom_range(1, 0));
			// Turbo only switches at a system-enable boundary
			repeat (2 * shell_cfg_pkg::SYS_DIV) step();
			n_sys = 0;
			n_cep = 0;
			n_cen = 0;
			n_snd = 0;
			n_opm0 = 0;
			n_opm1 = 0;
			for (int c = 0; c < WIN; c++) begin
				step();
				n_sys  += int'(sys_ce_o);
				n_cep  += int'(mpu_cep_o);
				n_cen  += int'(mpu_cen_o);
				n_snd  += int'(snd_ce_o);
				n_opm0 += int'(opm_ce_o[0]);
				n_opm1 += int'(opm_ce_o[1]);
				check("mpu_cep_o&mpu_cen_o", 32'(mpu_cep_o & mpu_cen_o), 0);
			end
			// Turbo gives one phase per clock, so each phase every second cycle
			cpu_period = ctrl_req_i.turbo ? 2 : shell_cfg_pkg::SYS_DIV;
			snd_period = ctrl_req_i.snd_mode ? shell_cfg_pkg::SND_DIV_SLOW
				: shell_cfg_pkg::SND_DIV_FAST;
			check("sys_ce_o count", n_sys, WIN / shell_cfg_pkg::SYS_DIV, 1);
			check("mpu_cep_o count", n_cep, WIN / cpu_period, 1);
			check("mpu_cen_o count", n_cen, WIN / cpu_period, 1);
			check("snd_ce_o count", n_snd, WIN / snd_period, 1);
			check("opm_ce_o[0] count", n_opm0, WIN / shell_cfg_pkg::SND_DIV_SLOW, 1);
			check("opm_ce_o[1] count", n_opm1, WIN / shell_cfg_pkg::OPM_DIV, 1);
		end
	endtask

	task automatic run_floppy();
		int d;
		int lead;
		int width;
		d = int'($urandom_range(1, 0));
		repeat ($urandom_range(20, 1)) step();
		pulse_mount(d);
		measure_pulse(SEL_EJECT + d, shell_cfg_pkg::MOUNT_HOLD + 8, lead, width);
		check($sformatf("fdd_eject_o[%0d] lead", d), lead, 0);
		check($sformatf("fdd_eject_o[%0d] width", d), width, shell_cfg_pkg::EJECT_HOLD);
		// Inserted disk shows right after the eject window
		measure_pulse(SEL_MOUNTED + d, shell_cfg_pkg::MOUNT_HOLD + 8, lead, width);
		check($sformatf("mounted_o[%0d] lead", d), lead, 0);
		check($sformatf("mounted_o[%0d] width", d), width,
			shell_cfg_pkg::MOUNT_HOLD - shell_cfg_pkg::EJECT_HOLD);

		ctrl_req_i.fdd_eject[d[0]] = 1'b1;
		step();
		ctrl_req_i.fdd_eject = '0;
		measure_pulse(SEL_EJECT + d, shell_cfg_pkg::MOUNT_HOLD + 8, lead, width);
		check($sformatf("fdd_eject_o[%0d] req lead", d), lead, 0);
		check($sformatf("fdd_eject_o[%0d] req width", d), width, shell_cfg_pkg::EJECT_HOLD);

		// SRAM image has no eject window
		pulse_mount(3);
		measure_pulse(SEL_MOUNTED + 3, shell_cfg_pkg::MOUNT_HOLD + 8, lead, width);
		check("mounted_o[3] lead", lead, 0);
		check("mounted_o[3] width", width, shell_cfg_pkg::MOUNT_HOLD);
	endtask

	task automatic run_core_reset();
		int lead;
		int width;
		int cnt;
		for (int c = 0; c < 16; c++) begin
			step();
			check("core_reset_o", 32'(core_reset_o), 1);
		end
		dl_active_i = 1'b1;
		cnt = 0;
		while (core_reset_o) begin
			step();
			cnt++;
			if (cnt > 4)
				timeout_fail("core_reset_o stayed high after the download started");
		end

		ctrl_req_i.user_reset = 1'b1;
		cnt = int'($urandom_range(5, 1));
		for (int c = 0; c < cnt; c++) begin
			step();
			check("core_reset_o", 32'(core_reset_o), 1);
		end
		ctrl_req_i.user_reset = 1'b0;
		step();
		check("core_reset_o", 32'(core_reset_o), 0);

		// Mount registers the hold and the output register adds a cycle
		pulse_mount(2);
		measure_pulse(SEL_CORE_RST, shell_cfg_pkg::HDD_RESET_HOLD + 8, lead, width);
		check("core_reset_o lead", lead, 1);
		check("core_reset_o width", width, shell_cfg_pkg::HDD_RESET_HOLD);
		// Hard-disk mount window already covered the reset lead and hold
		measure_pulse(SEL_MOUNTED + 2, shell_cfg_pkg::MOUNT_HOLD + 8, lead, width);
		check("mounted_o[2] lead", lead, 0);
		check("mounted_o[2] width", width,
			shell_cfg_pkg::MOUNT_HOLD - shell_cfg_pkg::HDD_RESET_HOLD - 1);
	endtask

	task automatic run_loader();
		shell_types_pkg::ldr_addr_t exp_addr[$];
		shell_types_pkg::ldr_data_t exp_data[$];
		int sent;
		int got;
		int in_flight;
		int held;
		int cycles;
		sent = 0;
		got = 0;
		in_flight = 0;
		held = 0;
		cycles = 0;
		while (got < NUM_WORDS) begin
			step();
			cycles++;
			if (cycles > 4000)
				timeout_fail("not all loader words reached the core");
			dl_wr_i = 1'b0;
			ldr_credit_i = 1'b0;
			check("ldr_enable_o", 32'(ldr_enable_o), 1);
			if (ldr_word_o.valid) begin
				if (exp_addr.size() == 0)
					check("ldr_word_o.valid", 1, 0);
				check("ldr_word_o.addr", 32'(ldr_word_o.addr), 32'(exp_addr.pop_front()));
				check("ldr_word_o.data", 32'(ldr_word_o.data), 32'(exp_data.pop_front()));
				held++;
				got++;
				check("words held without credit", 32'(held <= shell_cfg_pkg::LDR_CREDITS), 1);
			end
			// Host keeps within the credit window
			if (sent < NUM_WORDS && in_flight < shell_cfg_pkg::LDR_CREDITS &&
					$urandom_range(2, 0) == 0) begin
				dl_wr_i = 1'b1;
				dl_addr_i = shell_types_pkg::ldr_addr_t'($urandom);
				dl_data_i = shell_types_pkg::ldr_data_t'($urandom);
				exp_addr.push_back(dl_addr_i);
				exp_data.push_back(dl_data_i);
				sent++;
				in_flight++;
			end
			if (held > 0 && $urandom_range(3, 0) == 0) begin
				ldr_credit_i = 1'b1;
				held--;
				in_flight--;
			end
		end
		while (held > 0) begin
			step();
			ldr_credit_i = 1'b1;
			held--;
		end
		step();
		ldr_credit_i = 1'b0;

		dl_active_i = 1'b0;
		cycles = 0;
		while (ldr_enable_o) begin
			step();
			cycles++;
			if (cycles > 8)
				timeout_fail("ldr_enable_o stayed high after the download ended");
		end
		repeat (4) step();
		// Done holds until reset so a second download stays disabled
		dl_active_i = 1'b1;
		for (int c = 0; c < 8; c++) begin
			step();
			check("ldr_enable_o after done", 32'(ldr_enable_o), 0);
		end
		dl_active_i = 1'b0;
	endtask

	task automatic run_leds();
		int fdd_left;
		int hdd_left;
		int gap;
		logic fdd_hit;
		logic hdd_hit;
		fdd_left = 0;
		hdd_left = 0;
		gap = 0;
		fdd_hit = 1'b0;
		hdd_hit = 1'b0;
		for (int c = 0; c < 1500; c++) begin
			step();
			if (fdd_hit)
				fdd_left = shell_cfg_pkg::LED_HOLD;
			else if (fdd_left > 0)
				fdd_left--;
			if (hdd_hit)
				hdd_left = shell_cfg_pkg::LED_HOLD;
			else if (hdd_left > 0)
				hdd_left--;
			check("fdd_led_o", 32'(fdd_led_o), 32'(fdd_left > 0));
			check("hdd_led_o", 32'(hdd_led_o), 32'(hdd_left > 0));
			sd_ack_i = '0;
			if (gap > 0)
				gap--;
			else begin
				sd_ack_i = shell_types_pkg::drive_mask_t'($urandom);
				// Idle gaps both shorter and longer than the afterglow
				if ($urandom_range(15, 0) == 0)
					gap = int'($urandom_range(100, 20));
			end
			fdd_hit = |sd_ack_i[1:0];
			hdd_hit = sd_ack_i[2];
		end
		sd_ack_i = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hd01f2521));
		reset_delayed = 1'b1;
		ctrl_req_i = '0;
		img_mounted_i = '0;
		dl_active_i = 1'b0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		sd_ack_i = '0;
		ldr_credit_i = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		check("enables in reset", 32'({sys_ce_o, mpu_cep_o, mpu_cen_o, snd_ce_o, opm_ce_o}), 0);
		check("mounted_o/fdd_eject_o in reset", 32'({mounted_o, fdd_eject_o}), 0);
		check("ldr_word_o.valid in reset", 32'(ldr_word_o.valid), 0);
		check("LEDs in reset", 32'({fdd_led_o, hdd_led_o}), 0);
		check("core_reset_o in reset", 32'(core_reset_o), 1);
		reset_delayed = 1'b0;

		run_enable_windows();
		run_floppy();
		run_core_reset();
		run_loader();
		run_leds();

		$display("** PASS **");
		$finish;
	end

endmodule

// File: src.f
rtl/shell_cfg_pkg.sv
rtl/shell_types_pkg.sv
rtl/ce_generator.sv
rtl/media_reset_seq.sv
rtl/loader_bridge.sv
rtl/activity_led.sv
rtl/guest_shell_top.sv
dv/tb_guest_shell.sv

// File: Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module tb_guest_shell

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module tb_guest_shell
	./obj_dir/Vtb_guest_shell 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
